// ==== design/rtc_pkg.sv ====
// Binary 24-hour time only; tick constants assume an 800 Hz update base and byte-wide registers.
package rtc_pkg;

    // --------------------
    // Tick timing
    localparam logic [31:0] tick_hz          = 32'd800;  // Tick enable rate.
    localparam logic [10:0] ticks_per_second = 11'd800;
    localparam logic [10:0] startup_ticks    = 11'd4;    // First second after reset or SET.

    // --------------------
    // Register map, byte address is index * 4
    localparam logic [5:0] reg_second       = 6'h00;
    localparam logic [5:0] reg_alarm_second = 6'h01;
    localparam logic [5:0] reg_minute       = 6'h02;
    localparam logic [5:0] reg_alarm_minute = 6'h03;
    localparam logic [5:0] reg_hour         = 6'h04;
    localparam logic [5:0] reg_alarm_hour   = 6'h05;
    localparam logic [5:0] reg_status_a     = 6'h0A;
    localparam logic [5:0] reg_control_b    = 6'h0B;
    localparam logic [5:0] reg_status_c     = 6'h0C;
    localparam logic [5:0] reg_status_d     = 6'h0D;

    localparam int axil_addr_w = 8;
    localparam int axil_data_w = 32;

    localparam int bit_set  = 7;  // Control B.
    localparam int bit_aie  = 5;
    localparam int bit_uie  = 4;
    localparam int bit_irqf = 7;  // Status C.
    localparam int bit_af   = 5;
    localparam int bit_uf   = 4;
    localparam int bit_uip  = 7;  // Status A.

    localparam logic [7:0] status_d_value = 8'h80;  // Valid RAM and time.
    localparam logic [1:0] alarm_any      = 2'b11;  // Alarm byte matches anything.

    typedef enum logic [1:0] {sel_second, sel_minute, sel_hour} time_sel_t;

    typedef enum logic [2:0] {
        sec_update_start,
        sec_update_busy,
        sec_second_start,
        sec_second_busy,
        sec_stopped
    } sec_state_t;

endpackage

// ==== design/rtc_if.sv ====
// Control and time bundles between the core blocks; irq_unit is the modport of the irq block.
`timescale 1ns/1ps

interface rtc_ctrl_if import rtc_pkg::*; ();

    logic       freeze;        // SET bit, stops updates.
    logic       aie;
    logic       uie;
    logic [7:0] alarm_second;
    logic [7:0] alarm_minute;
    logic [7:0] alarm_hour;
    logic       time_wr_en;    // Host write strobe.
    time_sel_t  time_wr_sel;
    logic [7:0] time_wr_data;
    logic       flag_clear;    // Status C was read.
    logic       uip;
    logic       uf;
    logic       af;
    logic       irq;

    modport regs (
        output freeze, aie, uie, alarm_second, alarm_minute, alarm_hour,
        output time_wr_en, time_wr_sel, time_wr_data, flag_clear,
        input  uip, uf, af, irq
    );
    modport seq (input freeze, output uip);
    modport counter (input time_wr_en, time_wr_sel, time_wr_data);
    modport irq_unit (
        input  aie, uie, alarm_second, alarm_minute, alarm_hour, flag_clear,
        output uf, af, irq
    );

endinterface

interface rtc_time_if ();

    logic [7:0] second;
    logic [7:0] minute;
    logic [7:0] hour;
    logic       second_done;   // Time just advanced.

    modport counter (output second, minute, hour, second_done);
    modport irq (input second, minute, hour, second_done);
    modport regs (input second, minute, hour);

endinterface

// ==== design/rtc_tick_gen.sv ====
// clk_hz must be at least tick_hz; tick is a one-cycle clock enable with fractional jitter.
`timescale 1ns/1ps

module rtc_tick_gen import rtc_pkg::*; #(
    parameter int unsigned clk_hz = 50_000_000
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    logic [31:0] acc;  // Phase, always below clk_hz.
    logic [32:0] sum;

    assign sum = {1'b0, acc} + {1'b0, tick_hz};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc  <= '0;
            tick <= 1'b0;
        end else if (sum >= {1'b0, clk_hz}) begin
            acc  <= 32'(sum - {1'b0, clk_hz});  // Keep the remainder.
            tick <= 1'b1;
        end else begin
            acc  <= sum[31:0];
            tick <= 1'b0;
        end
    end

endmodule

// ==== design/rtc_second_seq.sv ====
// Assumes at least two clk cycles per tick; SET holds the sequencer in stopped.
`timescale 1ns/1ps

module rtc_second_seq import rtc_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    tick,
    rtc_ctrl_if.seq ctrl,
    output logic    second_start
);

    sec_state_t  state;
    logic [10:0] countdown;  // Ticks left in the current second.
    logic        expire;

    assign expire = tick && (countdown == 11'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            countdown <= startup_ticks;
        end else if (ctrl.freeze) begin
            countdown <= startup_ticks;  // Restart a short first second.
        end else if (tick) begin
            countdown <= (countdown == 11'd0) ? ticks_per_second - 11'd1 : countdown - 11'd1;
        end
    end

    // --------------------
    // Once-per-second cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= sec_update_start;
        end else if (ctrl.freeze) begin
            state <= sec_stopped;
        end else begin
            case (state)
                sec_stopped:      state <= sec_update_start;
                sec_update_start: state <= expire ? sec_second_start : sec_update_busy;
                sec_update_busy:  if (expire) state <= sec_second_start;
                sec_second_start: state <= sec_second_busy;
                sec_second_busy:  if (countdown == 11'd1) state <= sec_update_start;
                default:          state <= sec_stopped;
            endcase
        end
    end

    assign second_start = (state == sec_second_start);

    // UIP covers the window around the time register update.
    assign ctrl.uip = (state == sec_update_start) || (state == sec_update_busy) ||
                      (state == sec_second_start);

endmodule

// ==== design/rtc_time_counter.sv ====
// Binary 24-hour time only; out-of-range host values roll to zero on the next update.
`timescale 1ns/1ps

module rtc_time_counter import rtc_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        second_start,
    rtc_ctrl_if.counter ctrl,
    rtc_time_if.counter tm
);

    logic sec_wrap;
    logic min_wrap;
    logic hour_wrap;

    assign sec_wrap  = tm.second >= 8'd59;
    assign min_wrap  = tm.minute >= 8'd59;
    assign hour_wrap = tm.hour >= 8'd23;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tm.second      <= '0;
            tm.minute      <= '0;
            tm.hour        <= '0;
            tm.second_done <= 1'b0;
        end else begin
            tm.second_done <= second_start && !ctrl.time_wr_en;  // No pulse if the host won.

            if (ctrl.time_wr_en) begin
                case (ctrl.time_wr_sel)
                    sel_second: tm.second <= ctrl.time_wr_data;
                    sel_minute: tm.minute <= ctrl.time_wr_data;
                    sel_hour:   tm.hour   <= ctrl.time_wr_data;
                    default:    ;
                endcase
            end else if (second_start) begin
                tm.second <= sec_wrap ? 8'd0 : tm.second + 8'd1;
                if (sec_wrap) begin
                    tm.minute <= min_wrap ? 8'd0 : tm.minute + 8'd1;  // Carry into minutes.
                    if (min_wrap) begin
                        tm.hour <= hour_wrap ? 8'd0 : tm.hour + 8'd1;
                    end
                end
            end
        end
    end

endmodule

// ==== design/rtc_irq_unit.sv ====
// Alarm is checked once per update against the new time; a flag set wins over a clear.
`timescale 1ns/1ps

module rtc_irq_unit import rtc_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    rtc_ctrl_if.irq_unit ctrl,
    rtc_time_if.irq      tm
);

    logic sec_match;
    logic min_match;
    logic hour_match;
    logic alarm_hit;

    assign sec_match  = (ctrl.alarm_second[7:6] == alarm_any) || (ctrl.alarm_second == tm.second);
    assign min_match  = (ctrl.alarm_minute[7:6] == alarm_any) || (ctrl.alarm_minute == tm.minute);
    assign hour_match = (ctrl.alarm_hour[7:6] == alarm_any) || (ctrl.alarm_hour == tm.hour);
    assign alarm_hit  = tm.second_done && sec_match && min_match && hour_match;

    // --------------------
    // Flags and request
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl.uf  <= 1'b0;
            ctrl.af  <= 1'b0;
            ctrl.irq <= 1'b0;
        end else begin
            ctrl.uf  <= (ctrl.uf && !ctrl.flag_clear) || tm.second_done;
            ctrl.af  <= (ctrl.af && !ctrl.flag_clear) || alarm_hit;
            // Follows the flags one cycle later.
            ctrl.irq <= !ctrl.flag_clear &&
                        ((ctrl.aie && ctrl.af) || (ctrl.uie && ctrl.uf));
        end
    end

endmodule

// ==== design/rtc_axil_regs.sv ====
// Single outstanding AXI4-Lite access per channel; only byte lane 0 carries register data.
`timescale 1ns/1ps

module rtc_axil_regs import rtc_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [axil_addr_w-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axil_data_w-1:0]   wdata,
    input  logic [axil_data_w/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [axil_addr_w-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [axil_data_w-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    rtc_ctrl_if.regs                 ctrl,
    rtc_time_if.regs                 tm
);

    logic [5:0] wr_idx;
    logic [5:0] rd_idx;
    logic       wr_fire;
    logic       wr_byte;
    logic       rd_fire;
    logic [7:0] rd_byte;

    assign wr_idx  = awaddr[axil_addr_w-1:2];
    assign rd_idx  = araddr[axil_addr_w-1:2];
    assign wr_fire = awready && awvalid && wvalid;
    assign wr_byte = wr_fire && wstrb[0];
    assign rd_fire = arready && arvalid;

    assign wready = awready;  // Address and data accepted together.
    assign bresp  = 2'b00;    // OKAY.
    assign rresp  = 2'b00;

    // --------------------
    // Write channel
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            awready <= awvalid && wvalid && !bvalid && !awready;  // One-cycle pulse.
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctrl.freeze       <= 1'b0;
            ctrl.aie          <= 1'b0;
            ctrl.uie          <= 1'b0;
            ctrl.alarm_second <= '0;
            ctrl.alarm_minute <= '0;
            ctrl.alarm_hour   <= '0;
        end else if (wr_byte) begin
            case (wr_idx)
                reg_alarm_second: ctrl.alarm_second <= wdata[7:0];
                reg_alarm_minute: ctrl.alarm_minute <= wdata[7:0];
                reg_alarm_hour:   ctrl.alarm_hour   <= wdata[7:0];
                reg_control_b: begin
                    ctrl.freeze <= wdata[bit_set];
                    ctrl.aie    <= wdata[bit_aie];
                    ctrl.uie    <= wdata[bit_uie] && !wdata[bit_set];  // SET masks UIE.
                end
                default: ;
            endcase
        end
    end

    // Time writes go straight to the counter in the accept cycle.
    always_comb begin
        ctrl.time_wr_en  = 1'b0;
        ctrl.time_wr_sel = sel_second;
        case (wr_idx)
            reg_second: ctrl.time_wr_en = wr_byte;
            reg_minute: begin
                ctrl.time_wr_en  = wr_byte;
                ctrl.time_wr_sel = sel_minute;
            end
            reg_hour: begin
                ctrl.time_wr_en  = wr_byte;
                ctrl.time_wr_sel = sel_hour;
            end
            default: ;
        endcase
    end

    assign ctrl.time_wr_data = wdata[7:0];

    // --------------------
    // Read channel
    always_comb begin
        rd_byte = 8'd0;  // Unmapped reads as zero.
        case (rd_idx)
            reg_second:       rd_byte = tm.second;
            reg_alarm_second: rd_byte = ctrl.alarm_second;
            reg_minute:       rd_byte = tm.minute;
            reg_alarm_minute: rd_byte = ctrl.alarm_minute;
            reg_hour:         rd_byte = tm.hour;
            reg_alarm_hour:   rd_byte = ctrl.alarm_hour;
            reg_status_a:     rd_byte[bit_uip] = ctrl.uip;
            reg_control_b: begin
                rd_byte[bit_set] = ctrl.freeze;
                rd_byte[bit_aie] = ctrl.aie;
                rd_byte[bit_uie] = ctrl.uie;
            end
            reg_status_c: begin
                rd_byte[bit_irqf] = ctrl.irq;
                rd_byte[bit_af]   = ctrl.af;
                rd_byte[bit_uf]   = ctrl.uf;
            end
            reg_status_d:     rd_byte = status_d_value;
            default:          ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= {{(axil_data_w - 8){1'b0}}, rd_byte};  // Held until rready.
        end
    end

    assign ctrl.flag_clear = rd_fire && (rd_idx == reg_status_c);  // Clear-on-read.

endmodule

// ==== design/rtc_top.sv ====
// clk_hz is fixed at build time and must be at least 1600 so that a tick spans two cycles.
`timescale 1ns/1ps

module rtc_top import rtc_pkg::*; #(
    parameter int unsigned clk_hz = 50_000_000
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [axil_addr_w-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axil_data_w-1:0]   wdata,
    input  logic [axil_data_w/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [axil_addr_w-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [axil_data_w-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     irq
);

    logic tick;
    logic second_start;

    rtc_ctrl_if u_ctrl_if ();
    rtc_time_if u_time_if ();

    rtc_tick_gen #(.clk_hz(clk_hz)) u_tick_gen (
        .clk  (clk),
        .rst_n(rst_n),
        .tick (tick)
    );

    rtc_second_seq u_second_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .tick        (tick),
        .ctrl        (u_ctrl_if.seq),
        .second_start(second_start)
    );

    rtc_time_counter u_time_counter (
        .clk         (clk),
        .rst_n       (rst_n),
        .second_start(second_start),
        .ctrl        (u_ctrl_if.counter),
        .tm          (u_time_if.counter)
    );

    rtc_irq_unit u_irq_unit (
        .clk  (clk),
        .rst_n(rst_n),
        .ctrl (u_ctrl_if.irq_unit),
        .tm   (u_time_if.irq)
    );

    rtc_axil_regs u_axil_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .awaddr (awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .wvalid (wvalid),
        .wready (wready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready),
        .araddr (araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready),
        .ctrl   (u_ctrl_if.regs),
        .tm     (u_time_if.regs)
    );

    assign irq = u_ctrl_if.irq;

endmodule

// ==== sim/rtc_assertions.sv ====
// Bound into rtc_top; the bus rules hold only outside reset, irq is checked during reset.
`timescale 1ns/1ps

module rtc_assertions import rtc_pkg::*; (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   bvalid,
    input logic                   bready,
    input logic                   rvalid,
    input logic                   rready,
    input logic [axil_data_w-1:0] rdata,
    input logic                   irq,
    input logic                   uf,
    input logic                   af
);

    // --------------------
    // AXI4-Lite responses
    bvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    rdata_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> $stable(rdata))
        else $error("rdata changed while rvalid waited");

    // --------------------
    // Interrupt request
    irq_has_flag: assert property (@(posedge clk) disable iff (!rst_n)
        irq |-> (uf || af))
        else $error("irq high with no status flag set");

    irq_reset_low: assert property (@(posedge clk) !rst_n |=> !irq)
        else $error("irq high during reset");

endmodule

bind rtc_top rtc_assertions u_rtc_assertions (
    .clk   (clk),
    .rst_n (rst_n),
    .bvalid(bvalid),
    .bready(bready),
    .rvalid(rvalid),
    .rready(rready),
    .rdata (rdata),
    .irq   (irq),
    .uf    (u_ctrl_if.uf),
    .af    (u_ctrl_if.af)
);

// ==== sim/tb_rtc_top.sv ====
// Runs rtc_top at clk_hz 1600 so one second is 1600 cycles; bus tasks must start on a falling edge.
`timescale 1ns/1ps

module tb_rtc_top import rtc_pkg::*; ();

    localparam int unsigned clk_hz            = 1600;
    localparam int          cycles_per_second = 1600;
    localparam int          bus_timeout       = 50;    // Cycles per handshake wait.
    localparam int          poll_limit        = 1000;  // Reads of second per elapsed second.
    localparam int          irq_latency       = 2;     // Flag, then irq.
    localparam logic [31:0] rand_seed         = 32'h321a_6ce3;

    typedef struct packed {
        logic [7:0] start_hour;
        logic [7:0] start_minute;
        logic [7:0] start_second;
        logic [7:0] alarm_hour;
        logic [7:0] alarm_minute;
        logic [7:0] alarm_second;
        logic [7:0] ctrl_b;
        logic [7:0] wait_s;
        logic [7:0] exp_hour;
        logic [7:0] exp_minute;
        logic [7:0] exp_second;
        logic [7:0] exp_status_c;
        logic       exp_irq;
    } entry_t;

    logic        clk;
    logic        rst_n;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        irq;
    int          error_count = 0;
    logic        run_over = 1'b0;

    // Start time, alarm, control B, seconds, expected time, status C, irq.
    entry_t test_table [8] = '{
        '{8'd12, 8'd59, 8'd59, 8'h3f, 8'h3f, 8'h3f, 8'h00, 8'd1, 8'd13, 8'd0, 8'd0, 8'h10, 1'b0},
        '{8'd23, 8'd59, 8'd58, 8'h3f, 8'h3f, 8'h3f, 8'h00, 8'd2, 8'd0, 8'd0, 8'd0, 8'h10, 1'b0},
        '{8'd6, 8'd45, 8'd20, 8'h3f, 8'h3f, 8'h3f, 8'h80, 8'd3, 8'd6, 8'd45, 8'd20, 8'h00, 1'b0},
        '{8'd10, 8'd20, 8'd30, 8'h3f, 8'h3f, 8'h3f, 8'h10, 8'd1, 8'd10, 8'd20, 8'd31, 8'h90, 1'b1},
        '{8'd8, 8'd30, 8'd0, 8'd8, 8'd30, 8'd1, 8'h20, 8'd1, 8'd8, 8'd30, 8'd1, 8'hb0, 1'b1},
        '{8'd8, 8'd30, 8'd0, 8'd8, 8'd30, 8'd1, 8'h00, 8'd1, 8'd8, 8'd30, 8'd1, 8'h30, 1'b0},
        '{8'd17, 8'd15, 8'd9, 8'hc0, 8'd15, 8'd10, 8'h20, 8'd1, 8'd17, 8'd15, 8'd10, 8'hb0, 1'b1},
        '{8'd5, 8'd15, 8'd9, 8'hc0, 8'd15, 8'd10, 8'h00, 8'd1, 8'd5, 8'd15, 8'd10, 8'h30, 1'b0}
    };

    rtc_top #(.clk_hz(clk_hz)) u_rtc_top (
        .clk    (clk),
        .rst_n  (rst_n),
        .awaddr (awaddr),
        .awvalid(awvalid),
        .awready(awready),
        .wdata  (wdata),
        .wstrb  (wstrb),
        .wvalid (wvalid),
        .wready (wready),
        .bresp  (bresp),
        .bvalid (bvalid),
        .bready (bready),
        .araddr (araddr),
        .arvalid(arvalid),
        .arready(arready),
        .rdata  (rdata),
        .rresp  (rresp),
        .rvalid (rvalid),
        .rready (rready),
        .irq    (irq)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns period.
    end

    // --------------------
    // Helpers
    task automatic stop_on_failure();
        run_over = 1'b1;
        $display("Simulation failed");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("FAIL t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic axi_write(input logic [5:0] idx, input logic [7:0] value);
        int waited;
        int delay;
        waited  = 0;
        delay   = int'($urandom % 32'd4);  // Back-pressure on bready.
        awaddr  = {idx, 2'b00};
        wdata   = 32'(value);
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge clk);
        while (!awready) begin
            waited++;
            if (waited > bus_timeout) begin
                $display("Timeout: awready never rose for a write to index 0x%0h", idx);
                stop_on_failure();
            end
            @(negedge clk);
        end
        check_value("wready", 32'(wready), 32'd1);  // Rises with awready.
        @(negedge clk);  // Accepted on the edge just passed.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        waited  = 0;
        while (!bvalid) begin
            waited++;
            if (waited > bus_timeout) begin
                $display("Timeout: no write response for index 0x%0h", idx);
                stop_on_failure();
            end
            @(negedge clk);
        end
        repeat (delay) @(negedge clk);
        check_value("bresp", 32'(bresp), 32'd0);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [5:0] idx, output logic [31:0] value);
        int waited;
        int delay;
        waited  = 0;
        delay   = int'($urandom % 32'd4);  // Back-pressure on rready.
        araddr  = {idx, 2'b00};
        arvalid = 1'b1;
        @(negedge clk);
        while (!arready) begin
            waited++;
            if (waited > bus_timeout) begin
                $display("Timeout: arready never rose for a read of index 0x%0h", idx);
                stop_on_failure();
            end
            @(negedge clk);
        end
        @(negedge clk);
        arvalid = 1'b0;
        waited  = 0;
        while (!rvalid) begin
            waited++;
            if (waited > bus_timeout) begin
                $display("Timeout: no read data for index 0x%0h", idx);
                stop_on_failure();
            end
            @(negedge clk);
        end
        repeat (delay) @(negedge clk);
        value = rdata;
        check_value("rresp", 32'(rresp), 32'd0);
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    // Each elapsed second shows up as a new value in the second register.
    task automatic wait_seconds(input logic [7:0] start_second, input int count);
        logic [7:0]  prev;
        logic [31:0] now;
        int          polls;
        prev = start_second;
        for (int n = 0; n < count; n++) begin
            polls = 0;
            axi_read(reg_second, now);
            while (now[7:0] == prev) begin
                polls++;
                if (polls > poll_limit) begin
                    $display("Timeout: the second register stopped advancing");
                    stop_on_failure();
                end
                axi_read(reg_second, now);
            end
            prev = now[7:0];
        end
    endtask

    task automatic apply_entry(input entry_t e);
        logic [31:0] value;
        axi_write(reg_control_b, 8'h80);  // Freeze while loading.
        axi_write(reg_hour, e.start_hour);
        axi_write(reg_minute, e.start_minute);
        axi_write(reg_second, e.start_second);
        axi_write(reg_alarm_hour, e.alarm_hour);
        axi_write(reg_alarm_minute, e.alarm_minute);
        axi_write(reg_alarm_second, e.alarm_second);
        axi_read(reg_status_c, value);  // Drop stale flags.
        axi_write(reg_control_b, e.ctrl_b);
        if (e.ctrl_b[bit_set]) begin
            repeat (int'(e.wait_s) * cycles_per_second) @(negedge clk);
        end else begin
            wait_seconds(e.start_second, int'(e.wait_s));
        end
        repeat (irq_latency) @(negedge clk);
        check_value("irq", 32'(irq), 32'(e.exp_irq));
        axi_read(reg_hour, value);
        check_value("hour", value, 32'(e.exp_hour));
        axi_read(reg_minute, value);
        check_value("minute", value, 32'(e.exp_minute));
        axi_read(reg_second, value);
        check_value("second", value, 32'(e.exp_second));
        axi_read(reg_status_c, value);
        check_value("status_c", value, 32'(e.exp_status_c));
        axi_read(reg_status_c, value);
        check_value("status_c after read", value, 32'd0);
        check_value("irq after read", 32'(irq), 32'd0);
    endtask

    // --------------------
    // Main sequence
    initial begin
        logic [31:0] value;
        void'($urandom(rand_seed));
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("irq after reset", 32'(irq), 32'd0);

        axi_write(reg_alarm_second, 8'h11);
        axi_write(reg_alarm_minute, 8'h22);
        axi_write(reg_alarm_hour, 8'h33);
        axi_read(reg_alarm_second, value);
        check_value("alarm_second", value, 32'h11);
        axi_read(reg_alarm_minute, value);
        check_value("alarm_minute", value, 32'h22);
        axi_read(reg_alarm_hour, value);
        check_value("alarm_hour", value, 32'h33);
        axi_read(reg_status_d, value);
        check_value("status_d", value, 32'h80);
        axi_read(6'h20, value);  // Unmapped.
        check_value("unmapped", value, 32'd0);

        for (int i = 0; i < $size(test_table); i++) begin
            apply_entry(test_table[i]);
        end

        axi_write(reg_control_b, 8'h90);  // SET masks UIE.
        axi_read(reg_control_b, value);
        check_value("control_b", value, 32'h80);

        run_over = 1'b1;
        if (error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Covers a run cut short elsewhere, such as by a failed assertion.
    final begin
        if (!run_over) begin
            $display("Simulation failed");
        end
    end

endmodule

// ==== sources.f ====
design/rtc_pkg.sv
design/rtc_if.sv
design/rtc_tick_gen.sv
design/rtc_second_seq.sv
design/rtc_time_counter.sv
design/rtc_irq_unit.sv
design/rtc_axil_regs.sv
design/rtc_top.sv
sim/rtc_assertions.sv
sim/tb_rtc_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_rtc_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "Run ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
